// ==== rtl/pb_pkg.sv ====
package pb_pkg;

  // Frame delimiters and special addresses
  localparam logic [7:0] sd2_delim      = 8'h68;
  localparam logic [7:0] end_delim      = 8'h16;
  localparam logic [7:0] broadcast_addr = 8'h7F;
  localparam int         max_payload    = 4;   // Payload bytes per frame, upper bound

  // One station's byte write toward the shared link (Wishbone classic)
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [7:0] dat;
  } link_req_t;

  typedef struct packed {
    logic ack;
  } link_rsp_t;

  // Frame request, payload byte 0 goes out first
  typedef struct packed {
    logic [7:0]                 da;
    logic [7:0]                 fc;
    logic [2:0]                 len;      // 1 to 4
    logic [max_payload*8-1:0]   payload;
  } frame_req_t;

  // Report of one received frame
  typedef struct packed {
    logic [7:0]                 da;
    logic [7:0]                 sa;
    logic [7:0]                 fc;
    logic [2:0]                 len;
    logic [max_payload*8-1:0]   payload;  // Unused bytes read as zero
    logic                       fcs_ok;
  } frame_rpt_t;

  typedef enum logic [3:0] {
    tx_idle, tx_sd, tx_le, tx_da, tx_sa, tx_fc, tx_data, tx_fcs, tx_ed
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_hunt, rx_le, rx_da, rx_sa, rx_fc, rx_data, rx_fcs, rx_ed
  } rx_state_t;

endpackage

// ==== rtl/pb_frame_tx.sv ====
module pb_frame_tx import pb_pkg::*; #(
  parameter logic [7:0] station_addr = 8'h02
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       req_valid,
  input  frame_req_t req,
  output logic       req_ready,
  output link_req_t  link_out,
  input  link_rsp_t  link_in
);

  tx_state_t  state;
  frame_req_t req_q;
  logic [1:0] byte_cnt;     // Payload byte being sent
  logic [7:0] fcs_sum;
  logic [7:0] tx_byte;
  logic [7:0] cur_data;
  logic [7:0] le_byte;
  logic       last_data;
  logic       accept;
  logic       active;

  assign req_ready = (state == tx_idle);
  assign accept    = req_valid && req_ready;
  assign active    = (state != tx_idle);

  assign cur_data  = req_q.payload[byte_cnt*8 +: 8];
  assign le_byte   = {5'd0, req_q.len} + 8'd3;          // DA, SA, FC plus payload
  assign last_data = ({1'b0, byte_cnt} + 3'd1) >= req_q.len;

  // Byte presented in each field
  always_comb begin
    case (state)
      tx_sd:   tx_byte = sd2_delim;
      tx_le:   tx_byte = le_byte;
      tx_da:   tx_byte = req_q.da;
      tx_sa:   tx_byte = station_addr;
      tx_fc:   tx_byte = req_q.fc;
      tx_data: tx_byte = cur_data;
      tx_fcs:  tx_byte = fcs_sum;
      tx_ed:   tx_byte = end_delim;
      default: tx_byte = 8'h00;
    endcase
  end

  // cyc and stb stay up for the whole frame, each ack moves to the next byte
  always_comb begin
    link_out.cyc = active;
    link_out.stb = active;
    link_out.we  = active;
    link_out.dat = tx_byte;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= tx_idle;
      byte_cnt <= '0;
    end else begin
      case (state)
        tx_idle: begin
          if (accept) begin
            state    <= tx_sd;
            byte_cnt <= '0;
          end
        end
        tx_sd:  if (link_in.ack) state <= tx_le;
        tx_le:  if (link_in.ack) state <= tx_da;
        tx_da:  if (link_in.ack) state <= tx_sa;
        tx_sa:  if (link_in.ack) state <= tx_fc;
        tx_fc:  if (link_in.ack) state <= tx_data;
        tx_data: begin
          if (link_in.ack) begin
            if (last_data) begin
              state <= tx_fcs;
            end else begin
              byte_cnt <= byte_cnt + 2'd1;
            end
          end
        end
        tx_fcs: if (link_in.ack) state <= tx_ed;
        tx_ed:  if (link_in.ack) state <= tx_idle;   // cyc drops for at least one cycle
        default: state <= tx_idle;
      endcase
    end
  end

  // Request copy and running checksum
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q   <= req;
      fcs_sum <= '0;
    end else if (link_in.ack) begin
      case (state)
        tx_da, tx_sa, tx_fc, tx_data: fcs_sum <= fcs_sum + tx_byte;
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/pb_line_arbiter.sv ====
module pb_line_arbiter import pb_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  link_req_t station_req [3],
  output link_rsp_t station_rsp [3],
  output link_req_t bus_req,
  input  link_rsp_t bus_rsp
);

  logic       busy_q;
  logic [1:0] grant_q;
  logic [1:0] last_q;       // Last winner, search starts after it
  logic [1:0] pick;
  logic       pick_valid;

  // Round robin search over stations with cyc raised
  always_comb begin
    int idx;
    pick_valid = 1'b0;
    pick       = last_q;
    // Walk downward so the nearest station after last_q wins
    for (int i = 3; i >= 1; i--) begin
      idx = (int'(last_q) + i) % 3;
      if (station_req[idx].cyc) begin
        pick_valid = 1'b1;
        pick       = 2'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q  <= 1'b0;
      grant_q <= 2'd0;
      last_q  <= 2'd2;      // Station 0 goes first
    end else if (!busy_q) begin
      if (pick_valid) begin
        busy_q  <= 1'b1;
        grant_q <= pick;
        last_q  <= pick;
      end
    end else if (!station_req[grant_q].cyc) begin
      busy_q <= 1'b0;       // Owner finished its frame
    end
  end

  // Granted request goes to the slave, nothing while idle
  always_comb begin
    if (busy_q) begin
      bus_req = station_req[grant_q];
    end else begin
      bus_req = '0;
    end
  end

  // ack only reaches the owner
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      station_rsp[i].ack = busy_q && (grant_q == 2'(i)) && bus_rsp.ack;
    end
  end

endmodule

// ==== rtl/pb_frame_rx.sv ====
module pb_frame_rx import pb_pkg::*; #(
  parameter logic [7:0] station_addr = 8'h05
) (
  input  logic       clk,
  input  logic       reset,
  input  link_req_t  bus_req,
  output link_rsp_t  bus_rsp,
  output logic       rpt_valid,
  output frame_rpt_t rpt
);

  rx_state_t                state;
  logic                     ack_q;
  logic                     take;        // Byte accepted on this edge
  logic [7:0]               dat;
  logic [7:0]               da_q;
  logic [7:0]               sa_q;
  logic [7:0]               fc_q;
  logic [2:0]               len_q;
  logic [max_payload*8-1:0] payload_q;
  logic [1:0]               byte_cnt;
  logic [7:0]               fcs_sum;
  logic                     fcs_ok_q;
  logic                     le_ok;
  logic                     addr_hit;

  assign dat         = bus_req.dat;
  assign bus_rsp.ack = ack_q;
  assign take        = bus_req.cyc && bus_req.stb && bus_req.we && ack_q;

  assign le_ok    = (dat >= 8'd4) && (dat <= 8'(max_payload + 3));
  assign addr_hit = (da_q == station_addr) || (da_q == broadcast_addr);

  // Every offered byte is acked one cycle late, two cycles per byte
  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_req.cyc && bus_req.stb && !ack_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= rx_hunt;
      byte_cnt  <= '0;
      rpt_valid <= 1'b0;
    end else begin
      rpt_valid <= 1'b0;
      if (!bus_req.cyc && state != rx_hunt) begin
        state <= rx_hunt;   // Sender gave up the link mid-frame
      end else if (take) begin
        case (state)
          rx_hunt: if (dat == sd2_delim) state <= rx_le;
          rx_le:   state <= le_ok ? rx_da : rx_hunt;
          rx_da:   state <= rx_sa;
          rx_sa:   state <= rx_fc;
          rx_fc: begin
            state    <= rx_data;
            byte_cnt <= '0;
          end
          rx_data: begin
            if (({1'b0, byte_cnt} + 3'd1) == len_q) begin
              state <= rx_fcs;
            end else begin
              byte_cnt <= byte_cnt + 2'd1;
            end
          end
          rx_fcs: state <= rx_ed;
          rx_ed: begin
            // Bad end delimiter drops the frame silently
            if (dat == end_delim && addr_hit) begin
              rpt_valid <= 1'b1;
            end
            state <= rx_hunt;
          end
          default: state <= rx_hunt;
        endcase
      end
    end
  end

  // Field capture and checksum
  always_ff @(posedge clk) begin
    if (take) begin
      case (state)
        rx_le:  len_q <= 3'(dat - 8'd3);
        rx_da: begin
          da_q    <= dat;
          fcs_sum <= dat;
        end
        rx_sa: begin
          sa_q    <= dat;
          fcs_sum <= fcs_sum + dat;
        end
        rx_fc: begin
          fc_q      <= dat;
          fcs_sum   <= fcs_sum + dat;
          payload_q <= '0;
        end
        rx_data: begin
          payload_q[byte_cnt*8 +: 8] <= dat;
          fcs_sum                    <= fcs_sum + dat;
        end
        rx_fcs: fcs_ok_q <= (dat == fcs_sum);
        rx_ed: begin
          rpt.da      <= da_q;
          rpt.sa      <= sa_q;
          rpt.fc      <= fc_q;
          rpt.len     <= len_q;
          rpt.payload <= payload_q;
          rpt.fcs_ok  <= fcs_ok_q;
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/pb_segment.sv ====
module pb_segment import pb_pkg::*; #(
  parameter logic [7:0] master0_addr = 8'h02,
  parameter logic [7:0] master1_addr = 8'h03,
  parameter logic [7:0] slave_addr   = 8'h05
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       m0_req_valid,
  input  frame_req_t m0_req,
  output logic       m0_req_ready,
  input  logic       m1_req_valid,
  input  frame_req_t m1_req,
  output logic       m1_req_ready,
  input  link_req_t  ext_req,
  output link_rsp_t  ext_rsp,
  output logic       rpt_valid,
  output frame_rpt_t rpt
);

  // Station 0 and 1 are the masters, station 2 is the external port
  link_req_t st_req [3];
  link_rsp_t st_rsp [3];
  link_req_t bus_req;
  link_rsp_t bus_rsp;

  assign st_req[2] = ext_req;
  assign ext_rsp   = st_rsp[2];

  pb_frame_tx #(.station_addr(master0_addr)) u_master0 (
    .clk       (clk),
    .reset     (reset),
    .req_valid (m0_req_valid),
    .req       (m0_req),
    .req_ready (m0_req_ready),
    .link_out  (st_req[0]),
    .link_in   (st_rsp[0])
  );

  pb_frame_tx #(.station_addr(master1_addr)) u_master1 (
    .clk       (clk),
    .reset     (reset),
    .req_valid (m1_req_valid),
    .req       (m1_req),
    .req_ready (m1_req_ready),
    .link_out  (st_req[1]),
    .link_in   (st_rsp[1])
  );

  pb_line_arbiter u_arbiter (
    .clk         (clk),
    .reset       (reset),
    .station_req (st_req),
    .station_rsp (st_rsp),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp)
  );

  pb_frame_rx #(.station_addr(slave_addr)) u_slave (
    .clk       (clk),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .rpt_valid (rpt_valid),
    .rpt       (rpt)
  );

endmodule

// ==== dv/pb_monitor.sv ====
module pb_monitor import pb_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       rpt_valid,
  input frame_rpt_t rpt
);
  timeunit 1ns;
  timeprecision 100ps;

  frame_rpt_t exp_q [256][$];   // Expected reports, one queue per source address
  int         error_count = 0;
  int         match_count = 0;

  task automatic push_expected(input frame_rpt_t e);
    exp_q[e.sa].push_back(e);
  endtask

  function automatic bit compare_field(input string name, input logic [31:0] expv,
                                       input logic [31:0] gotv);
    if (expv !== gotv) begin
      $display("FAIL rpt.%s expected 0x%0h got 0x%0h", name, expv, gotv);
      error_count++;
      return 1'b0;
    end
    return 1'b1;
  endfunction

  // Report is stable around the falling edge
  always @(negedge clk) begin : watch_reports
    frame_rpt_t e;
    bit         ok;
    if (!reset && rpt_valid) begin
      if (exp_q[rpt.sa].size() == 0) begin
        $display("Frame report from source address 0x%02h arrived with no frame expected",
                 rpt.sa);
        error_count++;
      end else begin
        e  = exp_q[rpt.sa].pop_front();
        ok = compare_field("da", 32'(e.da), 32'(rpt.da));
        ok = compare_field("fc", 32'(e.fc), 32'(rpt.fc)) && ok;
        ok = compare_field("len", 32'(e.len), 32'(rpt.len)) && ok;
        ok = compare_field("payload", e.payload, rpt.payload) && ok;
        ok = compare_field("fcs_ok", 32'(e.fcs_ok), 32'(rpt.fcs_ok)) && ok;
        if (ok) match_count++;
      end
    end
  end

  function automatic void check_drained();
    for (int i = 0; i < 256; i++) begin
      if (exp_q[i].size() != 0) begin
        $display("%0d expected frames from source address 0x%02h were never reported",
                 exp_q[i].size(), i);
        error_count++;
      end
    end
  endfunction

endmodule

// ==== dv/pb_tb.sv ====
module pb_tb import pb_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [7:0] master0_addr     = 8'h02;
  localparam logic [7:0] master1_addr     = 8'h03;
  localparam logic [7:0] slave_addr       = 8'h05;
  localparam logic [7:0] ext_addr         = 8'h21;   // SA used by the external port
  localparam int         drive_delay      = 2;
  localparam int         num_rounds       = 40;
  localparam int         frames_per_round = 4;       // Two masters plus up to two external
  localparam longint     timeout_ns       = num_rounds * frames_per_round * 40 * 20 + 20000;

  logic       clk;
  logic       reset;
  logic       m0_req_valid, m1_req_valid;
  frame_req_t m0_req, m1_req;
  logic       m0_req_ready, m1_req_ready;
  link_req_t  ext_req;
  link_rsp_t  ext_rsp;
  logic       rpt_valid;
  frame_rpt_t rpt;
  logic [7:0] ext_bytes [$];   // Raw burst for the external port
  int         stim_errors = 0;

  pb_segment #(
    .master0_addr (master0_addr),
    .master1_addr (master1_addr),
    .slave_addr   (slave_addr)
  ) UUT (
    .clk          (clk),
    .reset        (reset),
    .m0_req_valid (m0_req_valid),
    .m0_req       (m0_req),
    .m0_req_ready (m0_req_ready),
    .m1_req_valid (m1_req_valid),
    .m1_req       (m1_req),
    .m1_req_ready (m1_req_ready),
    .ext_req      (ext_req),
    .ext_rsp      (ext_rsp),
    .rpt_valid    (rpt_valid),
    .rpt          (rpt)
  );

  pb_monitor u_monitor (.clk(clk), .reset(reset), .rpt_valid(rpt_valid), .rpt(rpt));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic bit reported(input logic [7:0] da);
    return (da == slave_addr) || (da == broadcast_addr);
  endfunction

  // Mostly the slave, some broadcast, some foreign addresses
  function automatic frame_req_t random_req();
    frame_req_t r;
    int         pick;
    pick      = $urandom_range(0, 9);
    r.da      = (pick < 7) ? slave_addr : (pick < 9) ? broadcast_addr
                                                     : 8'h40 + 8'($urandom_range(0, 15));
    r.fc      = 8'($urandom_range(0, 255));
    r.len     = 3'($urandom_range(1, max_payload));
    r.payload = $urandom;
    return r;
  endfunction

  // Sum of DA, SA, FC and the sent payload bytes, modulo 256
  function automatic logic [7:0] frame_fcs(input frame_req_t r, input logic [7:0] sa);
    logic [7:0] sum;
    sum = r.da + sa + r.fc;
    for (int i = 0; i < int'(r.len); i++) sum = sum + r.payload[i*8 +: 8];
    return sum;
  endfunction

  function automatic frame_rpt_t expected_rpt(input frame_req_t r, input logic [7:0] sa,
                                              input bit fcs_ok);
    frame_rpt_t e;
    e.da      = r.da;
    e.sa      = sa;
    e.fc      = r.fc;
    e.len     = r.len;
    e.payload = '0;   // Bytes past len are never sent
    for (int i = 0; i < int'(r.len); i++) e.payload[i*8 +: 8] = r.payload[i*8 +: 8];
    e.fcs_ok  = fcs_ok;
    return e;
  endfunction

  function automatic logic [7:0] filler_byte();
    logic [7:0] b;
    b = 8'($urandom_range(0, 255));
    return (b == sd2_delim) ? 8'h00 : b;
  endfunction

  function automatic void append_frame(input frame_req_t r, input logic [7:0] fcs_flip,
                                       input logic [7:0] ed);
    ext_bytes.push_back(sd2_delim);
    ext_bytes.push_back(8'(r.len) + 8'd3);
    ext_bytes.push_back(r.da);
    ext_bytes.push_back(ext_addr);
    ext_bytes.push_back(r.fc);
    for (int i = 0; i < int'(r.len); i++) ext_bytes.push_back(r.payload[i*8 +: 8]);
    ext_bytes.push_back(frame_fcs(r, ext_addr) ^ fcs_flip);
    ext_bytes.push_back(ed);
  endfunction

  function automatic bit ready_of(input int m);
    return (m == 0) ? m0_req_ready : m1_req_ready;
  endfunction

  task automatic send_request(input int m, input frame_req_t r);
    if (m == 0) begin
      m0_req       = r;
      m0_req_valid = 1'b1;
    end else begin
      m1_req       = r;
      m1_req_valid = 1'b1;
    end
    @(negedge clk);
    while (!ready_of(m)) @(negedge clk);   // Held while a frame is in flight
    @(posedge clk);
    #(drive_delay);
    if (m == 0) m0_req_valid = 1'b0;
    else m1_req_valid = 1'b0;
  endtask

  task automatic run_master_frame(input int m);
    frame_req_t r;
    r = random_req();
    if (reported(r.da))
      u_monitor.push_expected(expected_rpt(r, (m == 0) ? master0_addr : master1_addr, 1'b1));
    send_request(m, r);
  endtask

  // Wishbone classic, one byte per ack, cyc held over the whole burst
  task automatic send_ext_burst();
    foreach (ext_bytes[i]) begin
      ext_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: ext_bytes[i]};
      @(negedge clk);
      while (!ext_rsp.ack) @(negedge clk);
      @(posedge clk);
      #(drive_delay);
    end
    ext_req = '0;
    @(posedge clk);
    #(drive_delay);
    ext_bytes.delete();
  endtask

  task automatic run_ext_sequence();
    frame_req_t r;
    int         kind;
    logic [7:0] flip;
    r    = random_req();
    kind = $urandom_range(0, 4);
    case (kind)
      2: repeat ($urandom_range(1, 3)) ext_bytes.push_back(filler_byte());
      3: append_frame(random_req(), 8'h00, end_delim ^ 8'($urandom_range(1, 255)));
      4: begin
        ext_bytes.push_back(sd2_delim);
        ext_bytes.push_back($urandom_range(0, 1) ? 8'($urandom_range(0, 3))
                                                 : 8'($urandom_range(8, 255)));
        repeat ($urandom_range(3, 6)) ext_bytes.push_back(filler_byte());
      end
      default: ;
    endcase
    flip = (kind == 1) ? 8'($urandom_range(1, 255)) : 8'h00;   // Corrupt FCS
    append_frame(r, flip, end_delim);
    if (reported(r.da)) u_monitor.push_expected(expected_rpt(r, ext_addr, flip == 8'h00));
    send_ext_burst();
  endtask

  task automatic check_idle_outputs(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (rpt_valid !== 1'b0) begin
        $display("FAIL rpt_valid expected 0x0 got 0x%0h", rpt_valid);
        stim_errors++;
      end
      if (m0_req_ready !== 1'b1) begin
        $display("FAIL m0_req_ready expected 0x1 got 0x%0h", m0_req_ready);
        stim_errors++;
      end
      if (m1_req_ready !== 1'b1) begin
        $display("FAIL m1_req_ready expected 0x1 got 0x%0h", m1_req_ready);
        stim_errors++;
      end
    end
    @(posedge clk);
    #(drive_delay);
  endtask

  initial begin
    int errors;
    void'($urandom(32'hd44d));
    reset        = 1'b1;
    m0_req_valid = 1'b0;
    m1_req_valid = 1'b0;
    m0_req       = '0;
    m1_req       = '0;
    ext_req      = '0;
    repeat (8) @(posedge clk);
    #(drive_delay);
    reset = 1'b0;
    check_idle_outputs(4);
    for (int rnd = 0; rnd < num_rounds; rnd++) begin
      fork   // All three sources contend for the link
        run_master_frame(0);
        run_master_frame(1);
        run_ext_sequence();
      join
    end
    @(negedge clk);
    while (!(m0_req_ready && m1_req_ready)) @(negedge clk);
    repeat (8) @(posedge clk);   // Last report drains
    u_monitor.check_drained();
    errors = u_monitor.error_count + stim_errors;
    $display("Reports matched %0d, monitor errors %0d, stimulus errors %0d",
             u_monitor.match_count, u_monitor.error_count, stim_errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("Timeout after %0d ns, the link stopped making progress", timeout_ns);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
rtl/pb_pkg.sv
rtl/pb_frame_tx.sv
rtl/pb_line_arbiter.sv
rtl/pb_frame_rx.sv
rtl/pb_segment.sv
dv/pb_monitor.sv
dv/pb_tb.sv

// ==== Makefile ====
# Verilator build and run for the Profibus segment testbench

VERILATOR ?= verilator
TOP       ?= pb_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
